/* Makefile */
SOURCES = all.f $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: run clean

run: obj_dir/Vgat_debug_tb
	@out="$$(./obj_dir/Vgat_debug_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

obj_dir/Vgat_debug_tb: $(SOURCES)
	verilator --binary --assert -f all.f --top-module gat_debug_tb -o Vgat_debug_tb

clean:
	rm -rf obj_dir

/* all.f */
+incdir+source
source/gat_dbg_pkg.sv
source/stage_status_monitor.sv
source/spmm_sample_probe.sv
source/debug_readout.sv
source/gat_debug_top.sv
bench/tb_clock_gen.sv
bench/gat_debug_tb.sv

/* bench/gat_debug_tb.sv */
`include "gat_dbg_cfg.svh"

module gat_debug_tb
  import gat_dbg_pkg::*;
();

  localparam int drive_dly      = 2;
  localparam int reset_wait_max = 40;    // Edges
  localparam int run_limit      = 40000;

  localparam rd_sel_t sel_cfg    = rd_sel_t'(`GAT_SEL_CFG);
  localparam rd_sel_t sel_status = rd_sel_t'(`GAT_SEL_STATUS);
  localparam rd_sel_t sel_count  = rd_sel_t'(`GAT_SEL_SM_COUNT);
  localparam rd_sel_t sel_samp_a = rd_sel_t'(`GAT_SEL_SAMPLE_A);
  localparam rd_sel_t sel_samp_b = rd_sel_t'(`GAT_SEL_SAMPLE_B);
  localparam rd_sel_t sel_build  = rd_sel_t'(`GAT_SEL_BUILD_ID);

  typedef struct packed {
    stage_bus_t lv;
    logic       wr_en;
    feat_addr_t wr_addr;
    wh_addr_t   wh_addr;
    sppe_lane_t lane2;
    logic       clr;
    rd_sel_t    sel;
    dbg_word_t  exp;
  } step_t;

  logic       clk;
  logic       rst_n;
  logic       spmm_vld;
  logic       spmm_rdy;
  logic       dmvm_vld;
  logic       dmvm_rdy;
  logic       sm_vld;
  logic       sm_rdy;
  logic       aggr_vld;
  logic       aggr_rdy;
  sppe_vec_t  sppe;
  wh_addr_t   wh_addr;
  logic       feat_wr_en;
  feat_addr_t feat_wr_addr;
  feat_data_t feat_wr_data;
  logic       status_clr;
  rd_sel_t    rd_sel;
  dbg_word_t  dbg_data;

  step_t       steps[$];
  logic [31:0] lfsr_q = 32'h04b89e37;
  int          checks = 0;
  int          mismatches = 0;
  int          failures = 0;

  tb_clock_gen clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_debug_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .spmm_vld_i     (spmm_vld),
    .spmm_rdy_i     (spmm_rdy),
    .dmvm_vld_i     (dmvm_vld),
    .dmvm_rdy_i     (dmvm_rdy),
    .sm_vld_i       (sm_vld),
    .sm_rdy_i       (sm_rdy),
    .aggr_vld_i     (aggr_vld),
    .aggr_rdy_i     (aggr_rdy),
    .sppe_i         (sppe),
    .wh_addr_i      (wh_addr),
    .feat_wr_en_i   (feat_wr_en),
    .feat_wr_addr_i (feat_wr_addr),
    .feat_wr_data_i (feat_wr_data),
    .status_clr_i   (status_clr),
    .rd_sel_i       (rd_sel),
    .dbg_data_o     (dbg_data)
  );

  // ==========================================================================
  // Random lane data
  // ==========================================================================
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];    // x^32 + x^22 + x^2 + x + 1
    return {s[30:0], fb};
  endfunction

  function automatic sppe_lane_t random_lane();
    sppe_lane_t v;
    v = '0;
    for (int b = 0; b < 12; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[10:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic fill_lanes(input sppe_lane_t lane2);
    for (int l = 0; l < 16; l++) begin
      sppe[l] = random_lane();
    end
    sppe[2] = lane2;                     // Probed lane
  endtask

  // ==========================================================================
  // Drive
  // ==========================================================================
  task automatic drive_step(input step_t s);
    spmm_vld     = s.lv.spmm.vld;
    spmm_rdy     = s.lv.spmm.rdy;
    dmvm_vld     = s.lv.dmvm.vld;
    dmvm_rdy     = s.lv.dmvm.rdy;
    sm_vld       = s.lv.sm.vld;
    sm_rdy       = s.lv.sm.rdy;
    aggr_vld     = s.lv.aggr.vld;
    aggr_rdy     = s.lv.aggr.rdy;
    feat_wr_en   = s.wr_en;
    feat_wr_addr = s.wr_addr;
    feat_wr_data = {s.wr_addr, s.wr_addr};
    wh_addr      = s.wh_addr;
    status_clr   = s.clr;
    rd_sel       = s.sel;
    fill_lanes(s.lane2);
  endtask

  task automatic drive_idle();
    spmm_vld     = 1'b0;
    spmm_rdy     = 1'b0;
    dmvm_vld     = 1'b0;
    dmvm_rdy     = 1'b0;
    sm_vld       = 1'b0;
    sm_rdy       = 1'b0;
    aggr_vld     = 1'b0;
    aggr_rdy     = 1'b0;
    feat_wr_en   = 1'b0;
    feat_wr_addr = '0;
    feat_wr_data = '0;
    wh_addr      = '0;
    status_clr   = 1'b0;
    fill_lanes(random_lane());           // Select left as it was
  endtask

  // ==========================================================================
  // Compare
  // ==========================================================================
  task automatic check_word(input string name, input dbg_word_t got, input dbg_word_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s got=0x%08h exp=0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input dbg_status_t got,
                              input dbg_status_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s got=0x%03h exp=0x%03h", $time, name, got, exp);
    end
  endtask

  // ==========================================================================
  // Table
  // ==========================================================================
  task automatic add_step(input stage_bus_t lv, input logic wr_en, input feat_addr_t wr_addr,
                          input wh_addr_t wh, input sppe_lane_t lane2, input logic clr,
                          input rd_sel_t sel, input dbg_word_t exp);
    step_t s;
    s = '{lv: lv, wr_en: wr_en, wr_addr: wr_addr, wh_addr: wh, lane2: lane2,
          clr: clr, sel: sel, exp: exp};
    steps.push_back(s);
  endtask

  task automatic build_table();
    // Reset values on every select
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_cfg, 32'd12);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h000);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_count, 32'd0);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_samp_a, 32'h000);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_samp_b, 32'h000);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_build, 32'd13090504);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, 3'd6, 32'h0);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, 3'd7, 32'h0);
    // Each stage level alone sets status bit level plus one
    add_step(8'b1000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h100);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h100);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b1, sel_status, 32'h000);
    add_step(8'b0100_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h080);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b1, sel_status, 32'h000);
    add_step(8'b0010_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h040);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b1, sel_status, 32'h000);
    add_step(8'b0001_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h020);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b1, sel_status, 32'h000);
    add_step(8'b0000_1000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h010);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b1, sel_status, 32'h000);
    add_step(8'b0000_0100, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h008);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b1, sel_status, 32'h000);
    add_step(8'b0000_0010, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h004);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b1, sel_status, 32'h000);
    add_step(8'b0000_0001, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h002);
    add_step(8'b1111_1111, 1'b0, 16'd0, 14'd0, 12'h000, 1'b1, sel_status, 32'h000);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h000);
    // Feature write limit
    add_step(8'b0000_0000, 1'b1, 16'd43327, 14'd0, 12'h000, 1'b0, sel_status, 32'h000);
    add_step(8'b0000_0000, 1'b0, 16'd43328, 14'd0, 12'h000, 1'b0, sel_status, 32'h000);
    add_step(8'b0000_0000, 1'b0, 16'd65535, 14'd0, 12'h000, 1'b0, sel_status, 32'h000);
    add_step(8'b0000_0000, 1'b1, 16'd43328, 14'd0, 12'h000, 1'b0, sel_status, 32'h001);
    add_step(8'b0000_0000, 1'b1, 16'd65535, 14'd0, 12'h000, 1'b0, sel_status, 32'h001);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h001);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b1, sel_status, 32'h000);
    // Lane 2 probe
    add_step(8'b0100_0000, 1'b0, 16'd0, 14'd10, 12'h5a3, 1'b0, sel_samp_a, 32'h5a3);
    add_step(8'b0100_0000, 1'b0, 16'd0, 14'd20, 12'hc71, 1'b0, sel_samp_b, 32'hc71);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd10, 12'h111, 1'b0, sel_samp_a, 32'h5a3);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd20, 12'h222, 1'b0, sel_samp_b, 32'hc71);
    add_step(8'b0100_0000, 1'b0, 16'd0, 14'd11, 12'h333, 1'b0, sel_samp_a, 32'h5a3);
    add_step(8'b0100_0000, 1'b0, 16'd0, 14'd21, 12'h444, 1'b0, sel_samp_b, 32'hc71);
    add_step(8'b0100_0000, 1'b0, 16'd0, 14'h100a, 12'h555, 1'b0, sel_samp_a, 32'h5a3);
    add_step(8'b0100_0000, 1'b0, 16'd0, 14'd10, 12'hfff, 1'b0, sel_samp_b, 32'hc71);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_samp_a, 32'hfff);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h080);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b1, sel_status, 32'h000);
    // Softmax valid count from two earlier cycles
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_count, 32'd2);
    add_step(8'b0000_1000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_count, 32'd3);
    add_step(8'b0000_1000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_count, 32'd4);
    add_step(8'b0000_0100, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_count, 32'd4);
    add_step(8'b0000_1000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_count, 32'd5);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_count, 32'd5);
    add_step(8'b0000_1000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_status, 32'h018);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_count, 32'd6);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_cfg, 32'd12);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, sel_build, 32'd13090504);
    // Unused codes with status, count and samples all nonzero
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, 3'd6, 32'h0);
    add_step(8'b0000_0000, 1'b0, 16'd0, 14'd0, 12'h000, 1'b0, 3'd7, 32'h0);
  endtask

  // Entry at one edge, idle at the next, readout after the one after
  task automatic run_table();
    step_t       s;
    dbg_word_t   got;
    dbg_status_t got_st;
    dbg_status_t exp_st;
    foreach (steps[i]) begin
      s = steps[i];
      @(posedge clk);
      #(drive_dly);
      drive_step(s);
      @(posedge clk);
      #(drive_dly);
      drive_idle();
      @(posedge clk);
      #(drive_dly);
      got = dbg_data;
      if (s.sel == sel_status) begin
        got_st = got[8:0];
        exp_st = s.exp[8:0];
        check_status("dbg_data_o.status", got_st, exp_st);
        if (got[31:9] != '0) begin
          failures++;
          $display("status readout of step %0d has nonzero upper bits", i);
        end
      end else begin
        check_word("dbg_data_o", got, s.exp);
      end
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    int waited;
    rd_sel = '0;
    drive_idle();
    build_table();
    waited = 0;
    while (rst_n !== 1'b1 && waited < reset_wait_max) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      failures++;
      $display("reset was never released");
    end else begin
      run_table();
    end
    $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(run_limit);
    $display("timeout, run did not end within %0d time units", run_limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int half_period  = 20;      // Period of 40
  localparam int reset_cycles = 16;

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;                       // Released off the edge
  end

endmodule

/* source/debug_readout.sv */
`include "gat_dbg_cfg.svh"

module debug_readout
  import gat_dbg_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           sm_vld_i,
  input  dbg_status_t    status_i,
  input  probe_samples_t samples_i,
  input  rd_sel_t        rd_sel_i,
  output dbg_word_t      dbg_data_o
);

  dbg_word_t sm_count_q;
  dbg_word_t rd_word;
  dbg_word_t dbg_data_q;

  // ========================================================================
  // Softmax valid counter
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_count_q <= '0;
    end else if (sm_vld_i) begin
      sm_count_q <= sm_count_q + dbg_word_t'(1);   // Wraps at 2^32
    end
  end

  // ========================================================================
  // Readout select
  // ========================================================================
  always_comb begin
    case (rd_sel_i)
      rd_sel_t'(`GAT_SEL_CFG): begin
        rd_word = dbg_word_t'(`GAT_H_NUM_SPARSE_DATA);
      end
      rd_sel_t'(`GAT_SEL_STATUS): begin
        rd_word = dbg_word_t'(status_i);        // Zero-extended
      end
      rd_sel_t'(`GAT_SEL_SM_COUNT): begin
        rd_word = sm_count_q;
      end
      rd_sel_t'(`GAT_SEL_SAMPLE_A): begin
        rd_word = dbg_word_t'(samples_i.sample_a);
      end
      rd_sel_t'(`GAT_SEL_SAMPLE_B): begin
        rd_word = dbg_word_t'(samples_i.sample_b);
      end
      rd_sel_t'(`GAT_SEL_BUILD_ID): begin
        rd_word = dbg_word_t'(`GAT_BUILD_ID);
      end
      default: begin
        rd_word = '0;                           // Unused codes
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dbg_data_q <= '0;
    end else begin
      dbg_data_q <= rd_word;
    end
  end

  assign dbg_data_o = dbg_data_q;

  // Unused select codes read back as zero one edge later
  property p_unused_sel_zero;
    @(posedge clk) disable iff (!rst_n)
      (rd_sel_i > rd_sel_t'(`GAT_SEL_BUILD_ID)) |=> (dbg_data_o == '0);
  endproperty

  a_unused_sel_zero: assert property (p_unused_sel_zero)
    else $error("dbg_data_o nonzero for unused select code");

endmodule

/* source/gat_dbg_cfg.svh */
`ifndef GAT_DBG_CFG_SVH
`define GAT_DBG_CFG_SVH

// ==========================================================================
// Build configuration and identification
// ==========================================================================
`define GAT_H_NUM_SPARSE_DATA 12        // Reported as configuration word
`define GAT_BUILD_ID          13090504  // Build identifier word

// Sparse PE lane probe
`define GAT_PROBE_ADDR_A      10        // Weight address for sample A
`define GAT_PROBE_ADDR_B      20        // Weight address for sample B
`define GAT_PROBE_LANE        2

// First illegal feature memory address
`define GAT_FEAT_ADDR_LIMIT   43328

// Readout select codes, 6 and 7 unused
`define GAT_SEL_CFG           0
`define GAT_SEL_STATUS        1
`define GAT_SEL_SM_COUNT      2
`define GAT_SEL_SAMPLE_A      3
`define GAT_SEL_SAMPLE_B      4
`define GAT_SEL_BUILD_ID      5
`endif

/* source/gat_dbg_pkg.sv */
package gat_dbg_pkg;

  // ========================================================================
  // Plain vector types
  // ========================================================================
  typedef logic [31:0] dbg_word_t;         // Readout word
  typedef logic [11:0] sppe_lane_t;        // One sparse PE output
  typedef sppe_lane_t [15:0] sppe_vec_t;   // All sparse PE lanes
  typedef logic [13:0] wh_addr_t;          // Weight memory address
  typedef logic [15:0] feat_addr_t;        // Feature memory address
  typedef logic [31:0] feat_data_t;        // Feature write data
  typedef logic [2:0]  rd_sel_t;           // Readout select

  // ========================================================================
  // Bundled status and sample types
  // ========================================================================
  typedef struct packed {
    logic vld;
    logic rdy;
  } stage_hs_t;

  // Stage order follows the inference pipeline, spmm in the MSBs
  typedef struct packed {
    stage_hs_t spmm;
    stage_hs_t dmvm;
    stage_hs_t sm;
    stage_hs_t aggr;
  } stage_bus_t;

  typedef struct packed {
    stage_bus_t sticky;                    // Ever-high record per level
    logic       feat_ovf;                  // Illegal feature write seen
  } dbg_status_t;

  typedef struct packed {
    sppe_lane_t sample_a;
    sppe_lane_t sample_b;
  } probe_samples_t;

endpackage

/* source/gat_debug_top.sv */
module gat_debug_top
  import gat_dbg_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       spmm_vld_i,
  input  logic       spmm_rdy_i,
  input  logic       dmvm_vld_i,
  input  logic       dmvm_rdy_i,
  input  logic       sm_vld_i,
  input  logic       sm_rdy_i,
  input  logic       aggr_vld_i,
  input  logic       aggr_rdy_i,
  input  sppe_vec_t  sppe_i,
  input  wh_addr_t   wh_addr_i,
  input  logic       feat_wr_en_i,
  input  feat_addr_t feat_wr_addr_i,
  input  feat_data_t feat_wr_data_i,     // Memory port shape only
  input  logic       status_clr_i,
  input  rd_sel_t    rd_sel_i,
  output dbg_word_t  dbg_data_o
);

  stage_bus_t     stage_bus;
  dbg_status_t    status;
  probe_samples_t samples;

  // ========================================================================
  // Stage level bundle
  // ========================================================================
  assign stage_bus = '{spmm: '{vld: spmm_vld_i, rdy: spmm_rdy_i},
                       dmvm: '{vld: dmvm_vld_i, rdy: dmvm_rdy_i},
                       sm:   '{vld: sm_vld_i,   rdy: sm_rdy_i},
                       aggr: '{vld: aggr_vld_i, rdy: aggr_rdy_i}};

  stage_status_monitor u_status (
    .clk            (clk),
    .rst_n          (rst_n),
    .stage_i        (stage_bus),
    .feat_wr_en_i   (feat_wr_en_i),
    .feat_wr_addr_i (feat_wr_addr_i),
    .status_clr_i   (status_clr_i),
    .status_o       (status)
  );

  spmm_sample_probe u_probe (
    .clk        (clk),
    .rst_n      (rst_n),
    .sppe_i     (sppe_i),
    .wh_addr_i  (wh_addr_i),
    .spmm_rdy_i (stage_bus.spmm.rdy),
    .samples_o  (samples)
  );

  debug_readout u_readout (
    .clk        (clk),
    .rst_n      (rst_n),
    .sm_vld_i   (stage_bus.sm.vld),
    .status_i   (status),
    .samples_i  (samples),
    .rd_sel_i   (rd_sel_i),
    .dbg_data_o (dbg_data_o)
  );

endmodule

/* source/spmm_sample_probe.sv */
`include "gat_dbg_cfg.svh"

module spmm_sample_probe
  import gat_dbg_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  sppe_vec_t      sppe_i,
  input  wh_addr_t       wh_addr_i,
  input  logic           spmm_rdy_i,
  output probe_samples_t samples_o
);

  probe_samples_t samples_q;
  sppe_lane_t     lane_val;
  logic           match_a;
  logic           match_b;

  // ========================================================================
  // Address match
  // ========================================================================
  assign lane_val = sppe_i[`GAT_PROBE_LANE];

  assign match_a = spmm_rdy_i && (wh_addr_i == wh_addr_t'(`GAT_PROBE_ADDR_A));
  assign match_b = spmm_rdy_i && (wh_addr_i == wh_addr_t'(`GAT_PROBE_ADDR_B));

  // ========================================================================
  // Sample registers
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      samples_q <= '0;
    end else begin
      if (match_a) begin
        samples_q.sample_a <= lane_val;
      end
      if (match_b) begin
        samples_q.sample_b <= lane_val;
      end
    end
  end

  assign samples_o = samples_q;

  // ========================================================================
  // Checks
  // ========================================================================
  // Sample A moves only after its own address hit
  property p_sample_a_stable;
    @(posedge clk) disable iff (!rst_n)
      !match_a |=> $stable(samples_o.sample_a);
  endproperty

  // Same for sample B
  property p_sample_b_stable;
    @(posedge clk) disable iff (!rst_n)
      !match_b |=> $stable(samples_o.sample_b);
  endproperty

  a_sample_a_stable: assert property (p_sample_a_stable)
    else $error("sample_a changed without probe A match");
  a_sample_b_stable: assert property (p_sample_b_stable)
    else $error("sample_b changed without probe B match");

endmodule

/* source/stage_status_monitor.sv */
`include "gat_dbg_cfg.svh"

module stage_status_monitor
  import gat_dbg_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  stage_bus_t  stage_i,
  input  logic        feat_wr_en_i,
  input  feat_addr_t  feat_wr_addr_i,
  input  logic        status_clr_i,
  output dbg_status_t status_o
);

  stage_bus_t sticky_q;
  stage_bus_t sticky_d;
  logic       ovf_q;
  logic       ovf_d;
  logic       ovf_hit;

  // ========================================================================
  // Set and clear
  // ========================================================================
  assign ovf_hit = feat_wr_en_i &&
                   (feat_wr_addr_i >= feat_addr_t'(`GAT_FEAT_ADDR_LIMIT));

  always_comb begin
    sticky_d = sticky_q | stage_i;      // Any high level sets its bit
    ovf_d    = ovf_q | ovf_hit;
    if (status_clr_i) begin             // Clear beats a same-cycle set
      sticky_d = '0;
      ovf_d    = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sticky_q <= '0;
      ovf_q    <= 1'b0;
    end else begin
      sticky_q <= sticky_d;
      ovf_q    <= ovf_d;
    end
  end

  assign status_o = '{sticky: sticky_q, feat_ovf: ovf_q};

  // ========================================================================
  // Checks
  // ========================================================================
  // Bits may only drop after a clear strobe
  property p_sticky_holds;
    @(posedge clk) disable iff (!rst_n)
      !status_clr_i |=> ((status_o & $past(status_o)) == $past(status_o));
  endproperty

  a_sticky_holds: assert property (p_sticky_holds)
    else $error("sticky status bit fell without status_clr_i");

endmodule
